//--- Makefile
TOP := FetchUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o simv
	./obj_dir/simv | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/BranchPredictor.sv
// Two-bit counter branch predictor with jump and branch pre-decode
// Gives a taken flag and target per lane of the held group
`timescale 1ns/1ps

module BranchPredictor (
    input  logic clk,
    input  logic rstN,
    input  logic predEnable,
    FetchGroupIf.predict grp,
    input  logic [FetchTypes::InsnWidth-1:0] laneInsn [FetchTypes::FetchWidth],
    input  logic [FetchTypes::PcWidth-1:0] lanePc [FetchTypes::FetchWidth],
    input  logic resolveValid,
    input  logic [FetchTypes::PcWidth-1:0] resolvePc,
    input  logic resolveTaken
);

    PredictTypes::CounterState counters [PredictTypes::CounterEntries];
    PredictTypes::InsnOp op [FetchTypes::FetchWidth];
    PredictTypes::CounterState laneCtr [FetchTypes::FetchWidth];
    PredictTypes::CounterState resolveCtr;
    logic [PredictTypes::CounterIndexWidth-1:0] resolveIdx;

    always_comb begin
        for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
            op[i] = PredictTypes::InsnOp'(laneInsn[i][PredictTypes::OpLsb +: PredictTypes::OpWidth]);
            laneCtr[i] = counters[lanePc[i][PredictTypes::CounterLsb +:
                                            PredictTypes::CounterIndexWidth]];
            // Target is PC plus the sign-extended word offset
            grp.predTarget[i] = lanePc[i]
                + {{PredictTypes::ImmExtBits{laneInsn[i][PredictTypes::ImmWidth-1]}},
                   laneInsn[i][PredictTypes::ImmWidth-1:0], 2'b00};
            // Jumps always go, branches only on an enabled taken counter
            grp.predTaken[i] = (op[i] == PredictTypes::OpJump)
                || (op[i] == PredictTypes::OpBranch && predEnable && laneCtr[i][1]);
        end
    end

    assign resolveIdx = resolvePc[PredictTypes::CounterLsb +: PredictTypes::CounterIndexWidth];
    assign resolveCtr = counters[resolveIdx];

    // Saturating update, visible to lookups in the next cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int e = 0; e < PredictTypes::CounterEntries; e++) begin
                counters[e] <= PredictTypes::WeakNot;
            end
        end else if (resolveValid) begin
            if (resolveTaken && resolveCtr != PredictTypes::StrongTaken) begin
                counters[resolveIdx] <= PredictTypes::CounterState'(resolveCtr + 2'd1);
            end else if (!resolveTaken && resolveCtr != PredictTypes::StrongNot) begin
                counters[resolveIdx] <= PredictTypes::CounterState'(resolveCtr - 2'd1);
            end
        end
    end

endmodule

//--- rtl/FetchConfigRegs.sv
// Configuration registers behind a four-phase req/ack write port
// Holds start PC and enables, and streams words into the instruction store
`timescale 1ns/1ps

module FetchConfigRegs (
    input  logic clk,
    input  logic rstN,
    input  logic cfgReq,
    input  FetchTypes::CfgAddr cfgAddr,
    input  logic [FetchTypes::CfgDataWidth-1:0] cfgData,
    output logic cfgAck,
    output logic [FetchTypes::PcWidth-1:0] startPc,
    output logic fetchEnable,
    output logic predEnable,
    output logic storeWe,
    output logic [FetchTypes::StoreAddrWidth-1:0] storeAddr,
    output logic [FetchTypes::InsnWidth-1:0] storeData
);

    logic doWrite;

    // One write per request, in the cycle before ack rises
    assign doWrite = cfgReq && !cfgAck;
    assign storeWe = doWrite && (cfgAddr == FetchTypes::CfgStoreData);
    assign storeData = cfgData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfgAck <= 1'b0;
            startPc <= '0;
            fetchEnable <= 1'b0;
            predEnable <= 1'b0;
            storeAddr <= '0;
        end else begin
            // Ack follows req by one cycle in both directions
            cfgAck <= cfgReq;
            if (doWrite) begin
                case (cfgAddr)
                    FetchTypes::CfgStart: startPc <= cfgData;
                    FetchTypes::CfgCtrl: {predEnable, fetchEnable} <= cfgData[1:0];
                    FetchTypes::CfgStoreAddr:
                        storeAddr <= cfgData[FetchTypes::StoreAddrWidth-1:0];
                    // Data write lands at storeAddr, then step to the next word
                    FetchTypes::CfgStoreData: storeAddr <= storeAddr + 1'b1;
                endcase
            end
        end
    end

    // Host keeps req up until ack has answered it
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
        $fell(cfgReq) |-> cfgAck);

endmodule

//--- rtl/FetchGroupIf.sv
// Fetch group link between next-PC, fetch and predictor blocks
`timescale 1ns/1ps

interface FetchGroupIf;

    // Group address from the next-PC stage, may be unaligned
    logic groupValid;
    logic [FetchTypes::PcWidth-1:0] groupPc;

    // Back pressure and taken-prediction redirect from the fetch stage
    logic stall;
    logic redirectValid;
    logic [FetchTypes::PcWidth-1:0] redirectPc;

    // Per-lane prediction for the group held in the fetch stage
    logic predTaken [FetchTypes::FetchWidth];
    logic [FetchTypes::PcWidth-1:0] predTarget [FetchTypes::FetchWidth];

    modport nextPc (output groupValid, groupPc, input stall, redirectValid, redirectPc);
    modport fetch (input groupValid, groupPc, predTaken, predTarget,
                   output stall, redirectValid, redirectPc);
    modport predict (output predTaken, predTarget);

endinterface

//--- rtl/FetchStage.sv
// Fetch stage
// Holds a group during cache lookup, stalls on a miss or downstream stall,
// applies predictions and registers the output lanes
`timescale 1ns/1ps

module FetchStage (
    input  logic clk,
    input  logic rstN,
    FetchGroupIf.fetch grp,
    input  logic outStall,
    input  logic beRedirectValid,
    output logic cacheValid,
    output logic [FetchTypes::PcWidth-1:0] cachePc,
    input  logic cacheHit,
    input  logic [FetchTypes::InsnWidth-1:0] cacheData [FetchTypes::FetchWidth],
    output logic [FetchTypes::InsnWidth-1:0] laneInsn [FetchTypes::FetchWidth],
    output logic [FetchTypes::PcWidth-1:0] lanePc [FetchTypes::FetchWidth],
    output FetchTypes::FetchLane outLane [FetchTypes::FetchWidth]
);

    logic pipeValid;
    logic [FetchTypes::PcWidth-1:0] pipePc;
    logic advance;
    logic laneValid [FetchTypes::FetchWidth];
    logic laneTaken [FetchTypes::FetchWidth];
    logic [FetchTypes::PcWidth-1:0] laneTarget [FetchTypes::FetchWidth];
    logic predLatched;
    logic heldTaken [FetchTypes::FetchWidth];
    logic [FetchTypes::PcWidth-1:0] heldTarget [FetchTypes::FetchWidth];
    FetchTypes::FetchLane nextLane [FetchTypes::FetchWidth];

    always_comb begin
        cacheValid = pipeValid;
        cachePc = {pipePc[FetchTypes::PcWidth-1:3], 3'b000};
        // Group leaves only on a hit with room downstream
        advance = pipeValid && cacheHit && !outStall;
        grp.stall = pipeValid && (!cacheHit || outStall);

        for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
            lanePc[i] = cachePc + FetchTypes::PcWidth'(i * FetchTypes::InsnBytes);
            laneInsn[i] = cacheData[i];
            // Lane 0 is dead when the group entered at an odd word
            laneValid[i] = pipeValid && (i != 0 || !pipePc[2]);
            laneTaken[i] = laneValid[i] && (predLatched ? heldTaken[i] : grp.predTaken[i]);
            laneTarget[i] = predLatched ? heldTarget[i] : grp.predTarget[i];
        end

        for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
            // Lane 1 is wrong-path behind a taken lane 0
            nextLane[i].valid = advance && laneValid[i] && !(i == 1 && laneTaken[0]);
            nextLane[i].pc = lanePc[i];
            nextLane[i].insn = laneInsn[i];
            nextLane[i].predTaken = laneTaken[i];
            nextLane[i].predTarget = laneTarget[i];
        end

        grp.redirectValid = advance && (laneTaken[0] || laneTaken[1]);
        grp.redirectPc = laneTaken[0] ? laneTarget[0] : laneTarget[1];
    end

    // Pipeline register, the presented group is wrong-path on any redirect
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pipeValid <= 1'b0;
        end else if (beRedirectValid || grp.redirectValid) begin
            pipeValid <= 1'b0;
        end else if (!grp.stall) begin
            pipeValid <= grp.groupValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!grp.stall) begin
            pipePc <= grp.groupPc;
        end
    end

    // Freeze the prediction once a hit is held back by outStall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            predLatched <= 1'b0;
        end else if (advance || beRedirectValid) begin
            predLatched <= 1'b0;
        end else if (pipeValid && cacheHit) begin
            predLatched <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!predLatched) begin
            heldTaken <= grp.predTaken;
            heldTarget <= grp.predTarget;
        end
    end

    // Output register holds under outStall, clears on a back-end redirect
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
                outLane[i] <= '0;
            end
        end else if (beRedirectValid) begin
            for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
                outLane[i].valid <= 1'b0;
            end
        end else if (!outStall) begin
            outLane <= nextLane;
        end
    end

    // After a taken lane the next group starts at its target and not at the fall-through
    noFallThroughAfterTaken: assert property (@(posedge clk) disable iff (!rstN)
        grp.redirectValid && grp.groupValid && !beRedirectValid
        |=> grp.groupPc == $past(grp.redirectPc));

endmodule

//--- rtl/FetchTypes.sv
// Fetch front end geometry, lane record and configuration register map
// Two lanes per group, groups aligned to 8 bytes, word-indexed backing store
package FetchTypes;

    // Group and instruction geometry
    localparam int FetchWidth = 2;
    localparam int PcWidth = 32;
    localparam int InsnWidth = 32;
    localparam int InsnBytes = 4;
    localparam int GroupBytes = 8;

    // Backing store, word index taken from PC bits 9:2
    localparam int StoreWords = 256;
    localparam int StoreAddrWidth = 8;

    // One group per cache line, index is PC 5:3 and tag is PC 9:6
    localparam int CacheLines = 8;
    localparam int IndexLsb = 3;
    localparam int IndexWidth = 3;
    localparam int TagLsb = 6;
    localparam int TagWidth = 4;
    localparam int MissPenalty = 4;
    localparam int MissCountWidth = 2;

    localparam int CfgDataWidth = 32;

    // One fetched instruction with its prediction
    typedef struct packed {
        logic valid;
        logic [PcWidth-1:0] pc;
        logic [InsnWidth-1:0] insn;
        logic predTaken;
        logic [PcWidth-1:0] predTarget;
    } FetchLane;

    // Config register addresses
    typedef enum logic [1:0] {
        CfgStart     = 2'd0,
        CfgCtrl      = 2'd1,
        CfgStoreAddr = 2'd2,
        CfgStoreData = 2'd3
    } CfgAddr;

endpackage

//--- rtl/FetchUnit.sv
// Two-wide fetch front end top level
// Connects config, next-PC, fetch, cache and predictor blocks to plain ports
`timescale 1ns/1ps

module FetchUnit (
    input  logic clk,
    input  logic rstN,
    input  logic cfgReq,
    input  FetchTypes::CfgAddr cfgAddr,
    input  logic [FetchTypes::CfgDataWidth-1:0] cfgData,
    output logic cfgAck,
    input  logic resolveValid,
    input  logic [FetchTypes::PcWidth-1:0] resolvePc,
    input  logic resolveTaken,
    input  logic beRedirectValid,
    input  logic [FetchTypes::PcWidth-1:0] beRedirectPc,
    input  logic outStall,
    output logic outValid [FetchTypes::FetchWidth],
    output logic [FetchTypes::PcWidth-1:0] outPc [FetchTypes::FetchWidth],
    output logic [FetchTypes::InsnWidth-1:0] outInsn [FetchTypes::FetchWidth],
    output logic outPredTaken [FetchTypes::FetchWidth],
    output logic [FetchTypes::PcWidth-1:0] outPredTarget [FetchTypes::FetchWidth]
);

    FetchGroupIf grp ();

    logic [FetchTypes::PcWidth-1:0] startPc;
    logic fetchEnable;
    logic predEnable;
    logic storeWe;
    logic [FetchTypes::StoreAddrWidth-1:0] storeAddr;
    logic [FetchTypes::InsnWidth-1:0] storeData;
    logic cacheValid;
    logic [FetchTypes::PcWidth-1:0] cachePc;
    logic cacheHit;
    logic [FetchTypes::InsnWidth-1:0] cacheData [FetchTypes::FetchWidth];
    logic [FetchTypes::InsnWidth-1:0] laneInsn [FetchTypes::FetchWidth];
    logic [FetchTypes::PcWidth-1:0] lanePc [FetchTypes::FetchWidth];
    FetchTypes::FetchLane outLane [FetchTypes::FetchWidth];

    FetchConfigRegs cfgRegs (
        .clk, .rstN, .cfgReq, .cfgAddr, .cfgData, .cfgAck,
        .startPc, .fetchEnable, .predEnable, .storeWe, .storeAddr, .storeData
    );

    NextPcStage nextPcStage (
        .clk, .rstN, .fetchEnable, .startPc, .beRedirectValid, .beRedirectPc, .grp(grp)
    );

    FetchStage fetchStage (
        .clk, .rstN, .grp(grp), .outStall, .beRedirectValid,
        .cacheValid, .cachePc, .cacheHit, .cacheData, .laneInsn, .lanePc, .outLane
    );

    InsnCache insnCache (
        .clk, .rstN, .lookupValid(cacheValid), .lookupPc(cachePc), .hit(cacheHit),
        .rdData(cacheData), .storeWe, .storeAddr, .storeData
    );

    BranchPredictor branchPredictor (
        .clk, .rstN, .predEnable, .grp(grp), .laneInsn, .lanePc,
        .resolveValid, .resolvePc, .resolveTaken
    );

    // Unpack the lane records onto flat output ports
    always_comb begin
        for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
            outValid[i] = outLane[i].valid;
            outPc[i] = outLane[i].pc;
            outInsn[i] = outLane[i].insn;
            outPredTaken[i] = outLane[i].predTaken;
            outPredTarget[i] = outLane[i].predTarget;
        end
    end

endmodule

//--- rtl/InsnCache.sv
// Direct-mapped instruction cache, one two-word group per line
// Misses refill from the writable backing store after a fixed penalty
`timescale 1ns/1ps

module InsnCache (
    input  logic clk,
    input  logic rstN,
    input  logic lookupValid,
    input  logic [FetchTypes::PcWidth-1:0] lookupPc,
    output logic hit,
    output logic [FetchTypes::InsnWidth-1:0] rdData [FetchTypes::FetchWidth],
    input  logic storeWe,
    input  logic [FetchTypes::StoreAddrWidth-1:0] storeAddr,
    input  logic [FetchTypes::InsnWidth-1:0] storeData
);

    logic [FetchTypes::InsnWidth-1:0] store [FetchTypes::StoreWords];
    logic [FetchTypes::InsnWidth-1:0] lineData [FetchTypes::CacheLines][FetchTypes::FetchWidth];
    logic [FetchTypes::TagWidth-1:0] lineTag [FetchTypes::CacheLines];
    logic lineValid [FetchTypes::CacheLines];

    logic busy;
    logic [FetchTypes::MissCountWidth-1:0] count;
    logic [FetchTypes::TagWidth-1:0] missTag;
    logic [FetchTypes::IndexWidth-1:0] missIdx;
    logic [FetchTypes::IndexWidth-1:0] idx;
    logic [FetchTypes::TagWidth-1:0] tag;
    logic startMiss;
    logic refillDone;

    assign idx = lookupPc[FetchTypes::IndexLsb +: FetchTypes::IndexWidth];
    assign tag = lookupPc[FetchTypes::TagLsb +: FetchTypes::TagWidth];
    assign hit = lookupValid && lineValid[idx] && (lineTag[idx] == tag);
    assign startMiss = lookupValid && !hit && !busy;
    assign refillDone = busy && (count == '0);

    always_comb begin
        for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
            rdData[i] = lineData[idx][i];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            count <= '0;
            for (int l = 0; l < FetchTypes::CacheLines; l++) begin
                lineValid[l] <= 1'b0;
            end
        end else begin
            if (startMiss) begin
                busy <= 1'b1;
                count <= FetchTypes::MissCountWidth'(FetchTypes::MissPenalty - 1);
            end else if (refillDone) begin
                busy <= 1'b0;
                lineValid[missIdx] <= 1'b1;
            end else if (busy) begin
                count <= count - 1'b1;
            end
            // Store writes drop a stale copy, after any refill in the same cycle
            if (storeWe && lineTag[storeAddr[3:1]] == storeAddr[7:4]) begin
                lineValid[storeAddr[3:1]] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (storeWe) begin
            store[storeAddr] <= storeData;
        end
        if (startMiss) begin
            missTag <= tag;
            missIdx <= idx;
        end
        if (refillDone) begin
            lineTag[missIdx] <= missTag;
            for (int i = 0; i < FetchTypes::FetchWidth; i++) begin
                lineData[missIdx][i] <= store[{missTag, missIdx, 1'(i)}];
            end
        end
    end

    // Fetch stage must hold its address for the whole refill
    lookupHeldDuringRefill: assert property (@(posedge clk) disable iff (!rstN)
        busy && lookupValid && $past(lookupValid) |-> $stable(lookupPc));

endmodule

//--- rtl/NextPcStage.sv
// Next-PC stage
// Picks the fetch group address each cycle from redirects, start PC or
// the sequential group
`timescale 1ns/1ps

module NextPcStage (
    input  logic clk,
    input  logic rstN,
    input  logic fetchEnable,
    input  logic [FetchTypes::PcWidth-1:0] startPc,
    input  logic beRedirectValid,
    input  logic [FetchTypes::PcWidth-1:0] beRedirectPc,
    FetchGroupIf.nextPc grp
);

    logic validReg;
    logic [FetchTypes::PcWidth-1:0] pcReg;
    logic [FetchTypes::PcWidth-1:0] seqPc;
    logic [FetchTypes::PcWidth-1:0] nextPc;

    // Sequential group starts at the next aligned 8-byte boundary
    assign seqPc = {pcReg[FetchTypes::PcWidth-1:3], 3'b000}
                 + FetchTypes::PcWidth'(FetchTypes::GroupBytes);

    always_comb begin
        nextPc = pcReg;
        if (beRedirectValid) begin
            nextPc = beRedirectPc;
        end else if (fetchEnable && !validReg) begin
            // First cycle after enable, validReg doubles as the delayed enable
            nextPc = startPc;
        end else if (grp.redirectValid) begin
            nextPc = grp.redirectPc;
        end else if (!grp.stall && validReg) begin
            nextPc = seqPc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validReg <= 1'b0;
        end else begin
            validReg <= fetchEnable;
        end
    end

    always_ff @(posedge clk) begin
        pcReg <= nextPc;
    end

    // Lane validity below an unaligned PC is sorted out in the fetch stage
    assign grp.groupValid = validReg;
    assign grp.groupPc = pcReg;

endmodule

//--- rtl/PredictTypes.sv
// Branch predictor definitions
// Opcode field, two-bit counter states and immediate layout
package PredictTypes;

    // Opcode lives in the top nibble
    localparam int OpLsb = 28;
    localparam int OpWidth = 4;

    // Signed word offset in the low 16 bits, shifted left by 2
    localparam int ImmWidth = 16;
    localparam int ImmExtBits = 14;

    // Counter table indexed by PC bits 7:2
    localparam int CounterEntries = 64;
    localparam int CounterLsb = 2;
    localparam int CounterIndexWidth = 6;

    typedef enum logic [3:0] {
        OpAlu    = 4'h0,
        OpBranch = 4'h1,
        OpJump   = 4'h2,
        OpNop    = 4'h3
    } InsnOp;

    typedef enum logic [1:0] {
        StrongNot   = 2'd0,
        WeakNot     = 2'd1,
        WeakTaken   = 2'd2,
        StrongTaken = 2'd3
    } CounterState;

endpackage

//--- src.f
rtl/FetchTypes.sv
rtl/PredictTypes.sv
rtl/FetchGroupIf.sv
rtl/FetchConfigRegs.sv
rtl/NextPcStage.sv
rtl/InsnCache.sv
rtl/BranchPredictor.sv
rtl/FetchStage.sv
rtl/FetchUnit.sv
tb/FetchUnitTb.sv

//--- tb/FetchUnitTb.sv
// Testbench for the two-wide fetch unit
// Directed tests compare every output lane with a model that walks the program
`timescale 1ns/1ps

module FetchUnitTb;

    // About 40 config writes of 2 cycles per test, plus up to 30 lanes at
    // 10 cycles each under misses and random stalls, six tests, with margin
    localparam int TimeoutCycles = 4000;
    // Long enough for a refill in flight to finish and leave the stage
    localparam int QuietCycles = FetchTypes::MissPenalty + 4;

    logic clk;
    logic rstN;
    logic cfgReq;
    FetchTypes::CfgAddr cfgAddr;
    logic [FetchTypes::CfgDataWidth-1:0] cfgData;
    logic cfgAck;
    logic resolveValid;
    logic [FetchTypes::PcWidth-1:0] resolvePc;
    logic resolveTaken;
    logic beRedirectValid;
    logic [FetchTypes::PcWidth-1:0] beRedirectPc;
    logic outStall;
    logic outValid [FetchTypes::FetchWidth];
    logic [FetchTypes::PcWidth-1:0] outPc [FetchTypes::FetchWidth];
    logic [FetchTypes::InsnWidth-1:0] outInsn [FetchTypes::FetchWidth];
    logic outPredTaken [FetchTypes::FetchWidth];
    logic [FetchTypes::PcWidth-1:0] outPredTarget [FetchTypes::FetchWidth];

    // Model state, store contents and counters as the rules leave them
    logic [31:0] storeModel [FetchTypes::StoreWords];
    int counterModel [PredictTypes::CounterEntries];
    FetchTypes::FetchLane expQ [$];
    logic [31:0] prog [$];
    logic [31:0] rngState;
    string testName;
    int errCount;
    int testErrStart;
    int passCount;
    int failCount;
    int cycleCount;

    FetchUnit UUT (
        .clk(clk), .rstN(rstN),
        .cfgReq(cfgReq), .cfgAddr(cfgAddr), .cfgData(cfgData), .cfgAck(cfgAck),
        .resolveValid(resolveValid), .resolvePc(resolvePc), .resolveTaken(resolveTaken),
        .beRedirectValid(beRedirectValid), .beRedirectPc(beRedirectPc),
        .outStall(outStall), .outValid(outValid), .outPc(outPc), .outInsn(outInsn),
        .outPredTaken(outPredTaken), .outPredTarget(outPredTarget)
    );

    always #20 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run stopped after %0d cycles in %s, DUT never finished", cycleCount,
                     testName);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] randomAlu();
        rngState = xorshift32(rngState);
        return {PredictTypes::OpAlu, rngState[27:0]};
    endfunction

    // PC plus sign-extended 16-bit word offset
    function automatic logic [31:0] branchTarget(input logic [31:0] pc,
                                                 input logic [31:0] insn);
        return pc + {{14{insn[15]}}, insn[15:0], 2'b00};
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("[FAIL] %s %s expected %h actual %h", testName, what, expVal, actVal);
        errCount++;
    endtask

    task automatic reportProblem(input string msg);
        $display("%s: %s", testName, msg);
        errCount++;
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrStart = errCount;
    endtask

    task automatic endTest();
        if (errCount == testErrStart) begin
            $display("%s: ok", testName);
            passCount++;
        end else begin
            $display("%s: %0d errors", testName, errCount - testErrStart);
            failCount++;
        end
    endtask

    // Four-phase write, ack must follow req by exactly one cycle each way
    task automatic cfgWrite(input FetchTypes::CfgAddr addr, input logic [31:0] data);
        int waitCycles;
        if (cfgAck !== 1'b0) reportProblem("cfgAck was already high before cfgReq rose");
        cfgReq = 1'b1;
        cfgAddr = addr;
        cfgData = data;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #2;
            waitCycles++;
        end while (cfgAck !== 1'b1);
        if (waitCycles != 1) reportProblem("cfgAck did not rise one cycle after cfgReq");
        cfgReq = 1'b0;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #2;
            waitCycles++;
        end while (cfgAck !== 1'b0);
        if (waitCycles != 1) reportProblem("cfgAck did not fall one cycle after cfgReq");
    endtask

    // Streams prog into the store from a word index, store address auto-increments
    task automatic writeProgram(input int baseWord);
        int k;
        cfgWrite(FetchTypes::CfgStoreAddr, baseWord);
        for (k = 0; k < prog.size(); k++) begin
            cfgWrite(FetchTypes::CfgStoreData, prog[k]);
            storeModel[(baseWord + k) % FetchTypes::StoreWords] = prog[k];
        end
        prog.delete();
    endtask

    // Walk lane by lane, a taken lane jumps and skips the rest of its group
    task automatic buildExpected(input logic [31:0] startPc, input int n, input logic predOn);
        logic [31:0] pc;
        logic [31:0] insn;
        FetchTypes::FetchLane lane;
        int k;
        expQ.delete();
        pc = startPc;
        for (k = 0; k < n; k++) begin
            insn = storeModel[pc[9:2]];
            lane.valid = 1'b1;
            lane.pc = pc;
            lane.insn = insn;
            // Counter values 2 and 3 are the taken states
            lane.predTaken = (insn[31:28] == PredictTypes::OpJump)
                || (insn[31:28] == PredictTypes::OpBranch && predOn
                    && counterModel[pc[7:2]] >= 2);
            lane.predTarget = branchTarget(pc, insn);
            expQ.push_back(lane);
            pc = lane.predTaken ? lane.predTarget : pc + 4;
        end
    endtask

    // A lane counts as taken at the edge where it is valid and outStall is low
    task automatic collectLanes(input int n, input logic randomStall);
        int got;
        int stallLeft;
        int i;
        FetchTypes::FetchLane e;
        got = 0;
        stallLeft = 0;
        while (got < n) begin
            @(negedge clk);
            if (!outStall) begin
                for (i = 0; i < FetchTypes::FetchWidth; i++) begin
                    if (outValid[i] === 1'b1 && got < n) begin
                        e = expQ[got];
                        if (outPc[i] !== e.pc) reportMismatch("pc", e.pc, outPc[i]);
                        if (outInsn[i] !== e.insn) reportMismatch("insn", e.insn, outInsn[i]);
                        if (outPredTaken[i] !== e.predTaken)
                            reportMismatch("predTaken", e.predTaken, outPredTaken[i]);
                        if (e.predTaken && outPredTarget[i] !== e.predTarget)
                            reportMismatch("predTarget", e.predTarget, outPredTarget[i]);
                        got++;
                    end
                end
            end
            @(posedge clk);
            #2;
            // Stall runs of 1 to 8 cycles, on or off at random
            if (randomStall) begin
                if (stallLeft == 0) begin
                    rngState = xorshift32(rngState);
                    outStall = rngState[0];
                    stallLeft = int'(rngState[3:1]) + 1;
                end
                stallLeft--;
            end
        end
        outStall = 1'b0;
    endtask

    task automatic drainOutputs();
        int quiet;
        quiet = 0;
        while (quiet < QuietCycles) begin
            @(negedge clk);
            quiet = (outValid[0] === 1'b1 || outValid[1] === 1'b1) ? 0 : quiet + 1;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic stopFetch();
        cfgWrite(FetchTypes::CfgCtrl, 32'd0);
        drainOutputs();
    endtask

    task automatic runFetch(input logic [31:0] startPc, input logic predOn, input int n,
                            input logic randomStall);
        cfgWrite(FetchTypes::CfgStart, startPc);
        buildExpected(startPc, n, predOn);
        cfgWrite(FetchTypes::CfgCtrl, {30'd0, predOn, 1'b1});
        collectLanes(n, randomStall);
        stopFetch();
    endtask

    task automatic resolveBranch(input logic [31:0] pc, input logic taken);
        int idx;
        resolveValid = 1'b1;
        resolvePc = pc;
        resolveTaken = taken;
        @(posedge clk);
        #2;
        resolveValid = 1'b0;
        // Saturating two-bit counter
        idx = pc[7:2];
        if (taken && counterModel[idx] < 3) counterModel[idx]++;
        if (!taken && counterModel[idx] > 0) counterModel[idx]--;
    endtask

    // Random ALU code at 0x40, ending in a jump to itself
    task automatic sequentialFetch();
        int k;
        startTest("sequentialFetch");
        for (k = 0; k < 20; k++) begin
            prog.push_back(randomAlu());
        end
        prog.push_back({PredictTypes::OpJump, 28'h0});
        prog.push_back({PredictTypes::OpNop, 28'h0});
        writeProgram(32'h10);
        // Unaligned start leaves lane 0 of the first group dead
        runFetch(32'h44, 1'b1, 22, 1'b0);
        endTest();
    endtask

    task automatic jumpFlush();
        startTest("jumpFlush");
        prog.push_back(randomAlu());
        prog.push_back(randomAlu());
        // Lane 0 jump to 0x120, the lane after it must vanish
        prog.push_back({PredictTypes::OpJump, 12'h0, 16'd6});
        prog.push_back(randomAlu());
        writeProgram(32'h40);
        prog.push_back(randomAlu());
        prog.push_back({PredictTypes::OpJump, 28'h0});
        writeProgram(32'h48);
        runFetch(32'h100, 1'b1, 6, 1'b0);
        endTest();
    endtask

    task automatic loopBranch();
        startTest("loopBranch");
        prog.push_back(randomAlu());
        prog.push_back(randomAlu());
        prog.push_back(randomAlu());
        // Branch at 0x20C back to 0x200
        prog.push_back({PredictTypes::OpBranch, 12'h0, 16'hFFFD});
        prog.push_back({PredictTypes::OpJump, 28'h0});
        prog.push_back({PredictTypes::OpNop, 28'h0});
        writeProgram(32'h80);
        // Counter starts weakly not taken
        runFetch(32'h200, 1'b1, 6, 1'b0);
        resolveBranch(32'h20C, 1'b1);
        resolveBranch(32'h20C, 1'b1);
        runFetch(32'h200, 1'b1, 9, 1'b0);
        // Same trained counter, predictor off
        runFetch(32'h200, 1'b0, 6, 1'b0);
        endTest();
    endtask

    task automatic stallHold();
        startTest("stallHold");
        runFetch(32'h40, 1'b1, 24, 1'b1);
        endTest();
    endtask

    task automatic backEndRedirect();
        startTest("backEndRedirect");
        cfgWrite(FetchTypes::CfgStart, 32'h40);
        buildExpected(32'h40, 6, 1'b1);
        cfgWrite(FetchTypes::CfgCtrl, 32'd3);
        collectLanes(6, 1'b0);
        // Lanes shown during the redirect cycle are squashed by the back end
        beRedirectValid = 1'b1;
        beRedirectPc = 32'h100;
        @(posedge clk);
        #2;
        beRedirectValid = 1'b0;
        buildExpected(32'h100, 6, 1'b1);
        collectLanes(6, 1'b0);
        stopFetch();
        endTest();
    endtask

    // Word 0x41 is PC 0x104, still cached from the earlier runs
    task automatic storeRewrite();
        startTest("storeRewrite");
        prog.push_back(storeModel[8'h41] ^ 32'h0000_5A5A);
        writeProgram(32'h41);
        runFetch(32'h100, 1'b1, 4, 1'b0);
        endTest();
    endtask

    initial begin
        int k;
        clk = 1'b0;
        rstN = 1'b0;
        cfgReq = 1'b0;
        cfgAddr = FetchTypes::CfgStart;
        cfgData = '0;
        resolveValid = 1'b0;
        resolvePc = '0;
        resolveTaken = 1'b0;
        beRedirectValid = 1'b0;
        beRedirectPc = '0;
        outStall = 1'b0;
        rngState = 32'd47524;
        errCount = 0;
        passCount = 0;
        failCount = 0;
        cycleCount = 0;
        testName = "reset";
        for (k = 0; k < PredictTypes::CounterEntries; k++) begin
            counterModel[k] = int'(PredictTypes::WeakNot);
        end
        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;
        if (cfgAck !== 1'b0 || outValid[0] !== 1'b0 || outValid[1] !== 1'b0)
            reportProblem("ack or valid outputs were not low after reset");

        sequentialFetch();
        jumpFlush();
        loopBranch();
        stallHold();
        backEndRedirect();
        storeRewrite();

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in all",
                 passCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
